// File: include/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Width of register values and memory words
`define LSU_XLEN 32

// Byte address into the data memory
// 8 bits give 256 bytes, so 64 words
`define LSU_ADDR_LEN 8

// Entries in the in-order access queue
`define LSU_QUEUE_DEPTH 4

`endif

// File: verilog/isa_pkg.sv
package isa_pkg;

    // Major opcodes of the RV32I memory instructions
    // Anything else reaching the unit is a fault
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    // funct3 field of loads and stores
    // Stores reuse the B, H and W codes for SB, SH and SW
    // BU and HU exist for loads only
    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_BU = 3'b100,
        F3_HU = 3'b101
    } funct3_e;

endpackage

// File: verilog/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

    // Width of one memory access
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } acc_size_e;

    // One decoded access waiting in the queue
    // Loads carry a zero mask, stores carry lane-aligned data
    typedef struct packed {
        logic                     is_load;
        logic                     is_signed;
        acc_size_e                size;
        logic [`LSU_ADDR_LEN-1:0] addr;
        logic [3:0]               wmask;
        logic [`LSU_XLEN-1:0]     wdata;
    } lsu_entry_t;

    // Queue sequencer state
    // WAIT means a memory read is in flight
    typedef enum logic {
        ISSUE_IDLE = 1'b0,
        ISSUE_WAIT = 1'b1
    } issue_state_e;

endpackage

// File: verilog/lsu_access_if.sv
interface lsu_access_if;

    import lsu_pkg::*;

    // One-cycle push strobe from decode
    logic       valid;
    // Decoded access that goes with the push
    lsu_entry_t entry;
    // Queue has no free slot
    logic       full;

    // Decode side pushes and watches full
    modport decode_mp (
        output valid,
        output entry,
        input  full
    );

    // Queue side takes pushes and reports full
    modport queue_mp (
        input  valid,
        input  entry,
        output full
    );

endinterface

// File: verilog/lsu_decode.sv
`include "lsu_defines.svh"

module lsu_decode (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  logic [`LSU_XLEN-1:0] inst_i,
    input  logic [`LSU_XLEN-1:0] rs1_i,
    input  logic [`LSU_XLEN-1:0] rs2_i,
    output logic                 ack_o,
    output logic                 fault_o,
    lsu_access_if.decode_mp      acc
);

    import isa_pkg::*;
    import lsu_pkg::*;

    logic                     ack_q;
    logic                     fault_q;
    logic                     is_load;
    logic                     is_store;
    funct3_e                  funct3;
    logic [`LSU_XLEN-1:0]     imm_i;
    logic [`LSU_XLEN-1:0]     imm_s;
    logic [`LSU_XLEN-1:0]     addr_full;
    logic [`LSU_ADDR_LEN-1:0] addr;
    acc_size_e                size;
    logic                     is_signed;
    logic                     f3_ok;
    logic                     aligned;
    logic                     legal;
    logic                     accept;
    logic [3:0]               wmask;
    logic [`LSU_XLEN-1:0]     wdata;

    // Field extraction
    assign is_load  = inst_i[6:0] == OP_LOAD;
    assign is_store = inst_i[6:0] == OP_STORE;
    assign funct3   = funct3_e'(inst_i[14:12]);
    assign imm_i    = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s    = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};

    // Effective address, only the low bits reach the memory
    assign addr_full = rs1_i + (is_store ? imm_s : imm_i);
    assign addr      = addr_full[`LSU_ADDR_LEN-1:0];

    // Size and extension from funct3
    always_comb begin
        size      = SIZE_W;
        is_signed = 1'b0;
        f3_ok     = 1'b1;
        case (funct3)
            F3_B: begin
                size      = SIZE_B;
                is_signed = 1'b1;
            end
            F3_H: begin
                size      = SIZE_H;
                is_signed = 1'b1;
            end
            F3_W: size = SIZE_W;
            // Unsigned forms have no store counterpart
            F3_BU: begin
                size  = SIZE_B;
                f3_ok = is_load;
            end
            F3_HU: begin
                size  = SIZE_H;
                f3_ok = is_load;
            end
            default: f3_ok = 1'b0;
        endcase
    end

    // Natural alignment check
    always_comb begin
        case (size)
            SIZE_H:  aligned = ~addr[0];
            SIZE_W:  aligned = addr[1:0] == 2'b00;
            default: aligned = 1'b1;
        endcase
    end

    // Byte lanes touched by a store, rs2 replicated so the mask picks the lane
    always_comb begin
        case (size)
            SIZE_B: begin
                wmask = 4'b0001 << addr[1:0];
                wdata = {4{rs2_i[7:0]}};
            end
            SIZE_H: begin
                wmask = 4'b0011 << {addr[1], 1'b0};
                wdata = {2{rs2_i[15:0]}};
            end
            default: begin
                wmask = 4'b1111;
                wdata = rs2_i;
            end
        endcase
        // Loads never write
        if (!is_store) begin
            wmask = 4'b0000;
        end
    end

    assign legal = (is_load || is_store) && f3_ok && aligned;

    // New request while idle and the queue has room
    assign accept = req_i && !ack_q && !acc.full;

    // Push in the accept cycle, queue captures at the same edge as ack
    assign acc.valid           = accept && legal;
    assign acc.entry.is_load   = is_load;
    assign acc.entry.is_signed = is_signed;
    assign acc.entry.size      = size;
    assign acc.entry.addr      = addr;
    assign acc.entry.wmask     = wmask;
    assign acc.entry.wdata     = wdata;

    // Ack half of the four-phase handshake
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            fault_q <= accept && !legal;
            if (accept) begin
                ack_q <= 1'b1;
            end else if (!req_i) begin
                ack_q <= 1'b0;
            end
        end
    end

    assign ack_o   = ack_q;
    assign fault_o = fault_q;

    // Ack only answers a pending request
    ack_needs_req_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i));

    // No push into a full queue
    no_push_full_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(acc.valid && acc.full));

endmodule

// File: verilog/lsu_queue.sv
`include "lsu_defines.svh"

module lsu_queue (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    lsu_access_if.queue_mp             acc,
    output logic                       mem_rd_en_o,
    output logic                       mem_wr_en_o,
    output logic [`LSU_ADDR_LEN-3:0]   mem_addr_o,
    output logic [3:0]                 mem_wmask_o,
    output logic [`LSU_XLEN-1:0]       mem_wdata_o,
    output logic                       rsp_valid_o,
    output logic                       rsp_is_load_o,
    output logic                       rsp_is_signed_o,
    output lsu_pkg::acc_size_e         rsp_size_o,
    output logic [1:0]                 rsp_offset_o
);

    import lsu_pkg::*;

    localparam int DEPTH = `LSU_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    lsu_entry_t       q_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    issue_state_e     state;
    lsu_entry_t       head;
    logic             empty;
    logic             push;
    logic             pop;
    logic             issue_rd;
    logic             issue_wr;

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head     = q_mem[rd_ptr];
    assign empty    = count == '0;
    assign acc.full = count == CNT_W'(DEPTH);
    assign push     = acc.valid;

    // Head issues only while no read is outstanding
    assign issue_rd = (state == ISSUE_IDLE) && !empty && head.is_load;
    assign issue_wr = (state == ISSUE_IDLE) && !empty && !head.is_load;

    // Stores leave on issue, loads after their data cycle
    assign pop = issue_wr || (state == ISSUE_WAIT);

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            q_mem[wr_ptr] <= acc.entry;
        end
    end

    // Pointers, occupancy and sequencer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            state  <= ISSUE_IDLE;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case (state)
                ISSUE_IDLE: begin
                    if (issue_rd) begin
                        state <= ISSUE_WAIT;
                    end
                end
                default: state <= ISSUE_IDLE;
            endcase
        end
    end

    // Memory side driven straight from the head entry
    assign mem_rd_en_o = issue_rd;
    assign mem_wr_en_o = issue_wr;
    assign mem_addr_o  = head.addr[`LSU_ADDR_LEN-1:2];
    assign mem_wmask_o = head.wmask;
    assign mem_wdata_o = head.wdata;

    // Read data is valid during WAIT, head still holds the load
    assign rsp_valid_o     = state == ISSUE_WAIT;
    assign rsp_is_load_o   = head.is_load;
    assign rsp_is_signed_o = head.is_signed;
    assign rsp_size_o      = head.size;
    assign rsp_offset_o    = head.addr[1:0];

    count_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count <= CNT_W'(DEPTH));

    // One memory operation per cycle
    rd_wr_excl_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(mem_rd_en_o && mem_wr_en_o));

endmodule

// File: verilog/lsu_load_align.sv
`include "lsu_defines.svh"

module lsu_load_align (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 rsp_valid_i,
    input  logic                 rsp_is_load_i,
    input  logic                 rsp_is_signed_i,
    input  lsu_pkg::acc_size_e   rsp_size_i,
    input  logic [1:0]           rsp_offset_i,
    input  logic [`LSU_XLEN-1:0] rdata_i,
    output logic                 wb_valid_o,
    output logic [`LSU_XLEN-1:0] wb_data_o
);

    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0] shifted;
    logic [`LSU_XLEN-1:0] ext;
    logic                 wb_valid_q;
    logic [`LSU_XLEN-1:0] wb_data_q;
    logic                 load_rsp;

    // Addressed lane down to bit 0
    // Halfword offsets are 0 or 2 so the same shift serves
    assign shifted = rdata_i >> {rsp_offset_i, 3'b000};

    // Sign or zero extension by size
    always_comb begin
        case (rsp_size_i)
            SIZE_B: begin
                ext = rsp_is_signed_i ? {{24{shifted[7]}}, shifted[7:0]}
                                      : {24'h0, shifted[7:0]};
            end
            SIZE_H: begin
                ext = rsp_is_signed_i ? {{16{shifted[15]}}, shifted[15:0]}
                                      : {16'h0, shifted[15:0]};
            end
            default: ext = rdata_i;
        endcase
    end

    // Stores never reach writeback
    assign load_rsp = rsp_valid_i && rsp_is_load_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= load_rsp;
        end
    end

    // Data register only loads on a response
    always_ff @(posedge clk_i) begin
        if (load_rsp) begin
            wb_data_q <= ext;
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_data_o  = wb_data_q;

endmodule

// File: verilog/dmem.sv
`include "lsu_defines.svh"

module dmem (
    input  logic                     clk_i,
    input  logic                     rd_en_i,
    input  logic                     wr_en_i,
    input  logic [`LSU_ADDR_LEN-3:0] addr_i,
    input  logic [3:0]               wmask_i,
    input  logic [`LSU_XLEN-1:0]     wdata_i,
    output logic [`LSU_XLEN-1:0]     rdata_o
);

    localparam int WORDS = 2 ** (`LSU_ADDR_LEN - 2);

    logic [`LSU_XLEN-1:0] mem [WORDS];
    logic [`LSU_XLEN-1:0] rdata_q;

    // Byte-masked write
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Registered read, data one cycle after rd_en
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rdata_q <= mem[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: verilog/lsu_top.sv
`include "lsu_defines.svh"

module lsu_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    output logic                 ack_o,
    input  logic [`LSU_XLEN-1:0] inst_i,
    input  logic [`LSU_XLEN-1:0] rs1_i,
    input  logic [`LSU_XLEN-1:0] rs2_i,
    output logic                 wb_valid_o,
    output logic [`LSU_XLEN-1:0] wb_data_o,
    output logic                 fault_o
);

    import lsu_pkg::*;

    // Queue to memory
    logic                     mem_rd_en;
    logic                     mem_wr_en;
    logic [`LSU_ADDR_LEN-3:0] mem_addr;
    logic [3:0]               mem_wmask;
    logic [`LSU_XLEN-1:0]     mem_wdata;
    logic [`LSU_XLEN-1:0]     mem_rdata;

    // Queue to load align
    logic                     rsp_valid;
    logic                     rsp_is_load;
    logic                     rsp_is_signed;
    acc_size_e                rsp_size;
    logic [1:0]               rsp_offset;

    // Decode to queue
    lsu_access_if acc_if ();

    lsu_decode u_decode (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .inst_i  (inst_i),
        .rs1_i   (rs1_i),
        .rs2_i   (rs2_i),
        .ack_o   (ack_o),
        .fault_o (fault_o),
        .acc     (acc_if.decode_mp)
    );

    lsu_queue u_queue (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .acc             (acc_if.queue_mp),
        .mem_rd_en_o     (mem_rd_en),
        .mem_wr_en_o     (mem_wr_en),
        .mem_addr_o      (mem_addr),
        .mem_wmask_o     (mem_wmask),
        .mem_wdata_o     (mem_wdata),
        .rsp_valid_o     (rsp_valid),
        .rsp_is_load_o   (rsp_is_load),
        .rsp_is_signed_o (rsp_is_signed),
        .rsp_size_o      (rsp_size),
        .rsp_offset_o    (rsp_offset)
    );

    lsu_load_align u_align (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .rsp_valid_i     (rsp_valid),
        .rsp_is_load_i   (rsp_is_load),
        .rsp_is_signed_i (rsp_is_signed),
        .rsp_size_i      (rsp_size),
        .rsp_offset_i    (rsp_offset),
        .rdata_i         (mem_rdata),
        .wb_valid_o      (wb_valid_o),
        .wb_data_o       (wb_data_o)
    );

    dmem u_dmem (
        .clk_i   (clk_i),
        .rd_en_i (mem_rd_en),
        .wr_en_i (mem_wr_en),
        .addr_i  (mem_addr),
        .wmask_i (mem_wmask),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

endmodule

// File: dv/lsu_tb.sv
`include "lsu_defines.svh"

module lsu_tb;

    // Inputs change this long after each rising edge, outputs are read there too
    localparam int DRIVE_DLY = 10;

    // Requests per test: fill, sw_lw, sub_store, load_ext, fault, burst
    localparam int NUM_REQS    = 128 + 8 + 12 + 13 + 13 + 40;
    localparam int CYCLE_LIMIT = NUM_REQS * 10 + 100;

    // RV32I encodings for loads and stores
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [2:0] FN_B  = 3'b000;
    localparam logic [2:0] FN_H  = 3'b001;
    localparam logic [2:0] FN_W  = 3'b010;
    localparam logic [2:0] FN_BU = 3'b100;
    localparam logic [2:0] FN_HU = 3'b101;
    localparam logic [2:0] LOAD_F3 [5] = '{FN_B, FN_H, FN_W, FN_BU, FN_HU};

    logic                 clk_i = 1'b0;
    logic                 rst_n_i;
    logic                 req_i;
    logic [`LSU_XLEN-1:0] inst_i;
    logic [`LSU_XLEN-1:0] rs1_i;
    logic [`LSU_XLEN-1:0] rs2_i;
    logic                 ack_o;
    logic                 wb_valid_o;
    logic [`LSU_XLEN-1:0] wb_data_o;
    logic                 fault_o;

    // Shadow of the data memory, one entry per byte address
    logic [7:0]  shadow [256];
    // Expected load results in issue order
    logic [31:0] exp_q [$];
    logic [31:0] mon_exp;

    integer seed;
    string  test_name;
    int     cycles;
    int     checks;
    int     errors;
    int     test_errors;
    int     tests_run;
    int     tests_failed;

    lsu_top uut (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .ack_o      (ack_o),
        .inst_i     (inst_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .wb_valid_o (wb_valid_o),
        .wb_data_o  (wb_data_o),
        .fault_o    (fault_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED test=%s %s expected=%h actual=%h",
                     test_name, what, expected, actual);
        end
    endtask

    // I-type load, rd = x3, rs1 = x1
    function automatic logic [31:0] load_inst(input logic [2:0] f3, input logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd3, OPC_LOAD};
    endfunction

    // S-type store, rs2 = x2, rs1 = x1
    function automatic logic [31:0] store_inst(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
    endfunction

    // Word fill that differs in every bit field with the word index
    function automatic logic [31:0] fill_pattern(input logic [5:0] w);
        return {w, 2'b00, w, 2'b01, w, 2'b10, w, 2'b11} ^ 32'ha5c3_1e77;
    endfunction

    // Reference: returns the fault flag, gives the load value
    // Legal stores update the shadow memory
    function automatic logic model_access(input logic [31:0] inst, input logic [31:0] rs1,
                                          input logic [31:0] rs2, output logic is_load,
                                          output logic [31:0] value);
        logic        is_store;
        logic [2:0]  f3;
        logic [31:0] imm;
        logic [31:0] addr_full;
        logic        sgn;
        logic        f3_ok;
        int          nbytes;
        int          base;
        is_load  = inst[6:0] == OPC_LOAD;
        is_store = inst[6:0] == OPC_STORE;
        f3       = inst[14:12];
        value    = 32'h0;
        imm = is_store ? {{20{inst[31]}}, inst[31:25], inst[11:7]}
                       : {{20{inst[31]}}, inst[31:20]};
        addr_full = rs1 + imm;
        base      = int'(addr_full[7:0]);
        f3_ok     = 1'b1;
        sgn       = 1'b0;
        nbytes    = 4;
        case (f3)
            FN_B: begin
                nbytes = 1;
                sgn    = 1'b1;
            end
            FN_H: begin
                nbytes = 2;
                sgn    = 1'b1;
            end
            FN_W: nbytes = 4;
            FN_BU: begin
                nbytes = 1;
                f3_ok  = is_load;
            end
            FN_HU: begin
                nbytes = 2;
                f3_ok  = is_load;
            end
            default: f3_ok = 1'b0;
        endcase
        // Faults: no memory opcode, bad funct3, unnatural alignment
        if (!(is_load || is_store) || !f3_ok || (base % nbytes) != 0) begin
            return 1'b1;
        end
        for (int i = 0; i < nbytes; i++) begin
            if (is_store) begin
                shadow[base + i] = rs2[8*i +: 8];
            end else begin
                value[8*i +: 8] = shadow[base + i];
            end
        end
        if (sgn && nbytes == 1) value = {{24{value[7]}}, value[7:0]};
        if (sgn && nbytes == 2) value = {{16{value[15]}}, value[15:0]};
        return 1'b0;
    endfunction

    // Four-phase handshake, returns fault_o as seen with the ack
    task automatic run_handshake(input logic [31:0] inst, input logic [31:0] rs1,
                                 input logic [31:0] rs2, output logic fault_seen);
        inst_i = inst;
        rs1_i  = rs1;
        rs2_i  = rs2;
        req_i  = 1'b1;
        do begin
            @(posedge clk_i);
            #DRIVE_DLY;
        end while (!ack_o);
        fault_seen = fault_o;
        req_i      = 1'b0;
        do begin
            @(posedge clk_i);
            #DRIVE_DLY;
        end while (ack_o);
    endtask

    // One instruction through model and DUT
    task automatic issue(input logic [31:0] inst, input logic [31:0] rs1,
                         input logic [31:0] rs2);
        logic        exp_fault;
        logic        is_load;
        logic        fault_seen;
        logic [31:0] value;
        exp_fault = model_access(inst, rs1, rs2, is_load, value);
        if (!exp_fault && is_load) exp_q.push_back(value);
        run_handshake(inst, rs1, rs2, fault_seen);
        compare_value("fault", {31'b0, exp_fault}, {31'b0, fault_seen});
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    // Wait for outstanding loads, then a few idle cycles to catch a stray writeback
    task automatic finish_test();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #DRIVE_DLY;
        end
        repeat (4) begin
            @(posedge clk_i);
            #DRIVE_DLY;
        end
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("test %-10s %s (%0d errors)", test_name, test_errors == 0 ? "ok" : "FAIL",
                 test_errors);
    endtask

    task automatic check_reset_idle();
        start_test("reset_idle");
        repeat (5) begin
            @(posedge clk_i);
            #DRIVE_DLY;
            compare_value("ack_o", 32'h0, {31'b0, ack_o});
            compare_value("wb_valid_o", 32'h0, {31'b0, wb_valid_o});
            compare_value("fault_o", 32'h0, {31'b0, fault_o});
        end
        finish_test();
    endtask

    // Every word written then read back
    task automatic fill_memory();
        start_test("fill");
        for (int w = 0; w < 64; w++) begin
            issue(store_inst(FN_W, 12'h000), 32'h2000 + 32'(w * 4), fill_pattern(6'(w)));
        end
        for (int w = 0; w < 64; w++) begin
            issue(load_inst(FN_W, 12'h004), 32'(w * 4) - 32'd4, 32'h0);
        end
        finish_test();
    endtask

    // Store with positive offset, load back with negative offset
    task automatic store_then_load();
        logic [31:0] addr;
        start_test("sw_lw");
        for (int k = 0; k < 4; k++) begin
            addr = 32'h1000_0000 + 32'(k * 20);
            issue(store_inst(FN_W, 12'h010), addr - 32'd16, $random(seed));
            issue(load_inst(FN_W, 12'hff8), addr + 32'd8, 32'h0);
        end
        finish_test();
    endtask

    task automatic subword_stores();
        start_test("sub_store");
        for (int off = 0; off < 4; off++) begin
            issue(store_inst(FN_B, 12'(off)), 32'h80, $random(seed));
            issue(load_inst(FN_W, 12'h000), 32'h80, 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(store_inst(FN_H, 12'(off)), 32'h80, $random(seed));
            issue(load_inst(FN_W, 12'h000), 32'h80, 32'h0);
        end
        finish_test();
    endtask

    // Lanes with both sign bit values
    task automatic load_extension();
        start_test("load_ext");
        issue(store_inst(FN_W, 12'h000), 32'h90, 32'h7f80_81ff);
        for (int off = 0; off < 4; off++) begin
            issue(load_inst(FN_B, 12'(off)), 32'h90, 32'h0);
            issue(load_inst(FN_BU, 12'(off)), 32'h90, 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(load_inst(FN_H, 12'(off)), 32'h90, 32'h0);
            issue(load_inst(FN_HU, 12'(off)), 32'h90, 32'h0);
        end
        finish_test();
    endtask

    task automatic misaligned_faults();
        start_test("fault");
        issue(load_inst(FN_H, 12'h001), 32'ha0, 32'h0);
        issue(load_inst(FN_H, 12'h003), 32'ha0, 32'h0);
        for (int off = 1; off < 4; off++) begin
            issue(load_inst(FN_W, 12'(off)), 32'ha0, 32'h0);
            issue(store_inst(FN_W, 12'(off)), 32'ha0, 32'hdead_beef);
        end
        issue(store_inst(FN_H, 12'h001), 32'ha0, 32'h1234_5678);
        issue(store_inst(FN_H, 12'h003), 32'ha0, 32'h1234_5678);
        // addi x1, x0, 1
        issue(32'h0010_0093, 32'ha0, 32'h0);
        // Unsigned funct3 on a store
        issue(store_inst(FN_BU, 12'h000), 32'ha0, 32'hffff_ffff);
        // Word must still hold its fill value
        issue(load_inst(FN_W, 12'h000), 32'ha0, 32'h0);
        finish_test();
    endtask

    // Random mix on the top 16 words, rs1 high bits are noise
    task automatic random_burst();
        logic [31:0] r_op;
        logic [31:0] r_addr;
        logic [31:0] r_hi;
        logic [31:0] rs1;
        logic [11:0] imm;
        logic [7:0]  a;
        logic [2:0]  f3;
        int          nbytes;
        start_test("burst");
        for (int i = 0; i < 40; i++) begin
            r_op   = $random(seed);
            r_addr = $random(seed);
            r_hi   = $random(seed);
            imm    = r_addr[27:16];
            if (r_op[0]) f3 = 3'(int'(r_op[3:1]) % 3);
            else f3 = LOAD_F3[int'(r_op[3:1]) % 5];
            nbytes = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
            a      = {2'b11, r_addr[5:0]} & ~8'(nbytes - 1);
            rs1    = {r_hi[31:8], 8'h00} + {24'h0, a} - {{20{imm[11]}}, imm};
            issue(r_op[0] ? store_inst(f3, imm) : load_inst(f3, imm), rs1, $random(seed));
        end
        finish_test();
    endtask

    // Writeback checker, outputs are registered so negedge sees them settled
    always @(negedge clk_i) begin
        if (rst_n_i && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                test_errors++;
                $display("Unexpected writeback of %h in test %s with no load pending",
                         wb_data_o, test_name);
            end else begin
                mon_exp = exp_q.pop_front();
                compare_value("wb_data_o", mon_exp, wb_data_o);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles in test %s",
                     CYCLE_LIMIT, test_name);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        seed         = 32'h7ab8_30c9;
        rst_n_i      = 1'b0;
        req_i        = 1'b0;
        inst_i       = 32'h0;
        rs1_i        = 32'h0;
        rs2_i        = 32'h0;
        test_name    = "reset";
        cycles       = 0;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk_i);
        #DRIVE_DLY;
        rst_n_i = 1'b1;

        check_reset_idle();
        fill_memory();
        store_then_load();
        subword_stores();
        load_extension();
        misaligned_faults();
        random_burst();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
verilog/isa_pkg.sv
verilog/lsu_pkg.sv
verilog/lsu_access_if.sv
verilog/lsu_decode.sv
verilog/lsu_queue.sv
verilog/lsu_load_align.sv
verilog/dmem.sv
verilog/lsu_top.sv
dv/lsu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the load-store unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module lsu_tb \
    -f sources.f \
    -o lsu_sim

./obj_dir/lsu_sim > sim.log
cat sim.log

if grep -q "Verification passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
